// ==== dataCache.f ====
hw/cachePkg.sv
hw/memBusPkg.sv
hw/refillBuffer.sv
hw/tagStore.sv
hw/dataStore.sv
hw/cacheCtrl.sv
hw/dataCache.sv
sim/tbClkGen.sv
sim/dataCache_props.sv
sim/tbDataCache.sv

// ==== Bender.yml ====
package:
  name: dataCache

sources:
  - files:
      - hw/cachePkg.sv
      - hw/memBusPkg.sv
      - hw/refillBuffer.sv
      - hw/tagStore.sv
      - hw/dataStore.sv
      - hw/cacheCtrl.sv
      - hw/dataCache.sv
  - target: simulation
    files:
      - sim/tbClkGen.sv
      - sim/dataCache_props.sv
      - sim/tbDataCache.sv

// ==== sim/tbDataCache.sv ====
`timescale 1ns/1ns

module tbDataCache;

  localparam int numTests      = 6;
  localparam int periodNs      = 20;
  localparam int respLimit     = 150;
  localparam int timeoutCycles = 200 * numTests + 2000;

  logic                               clk;
  logic                               rst_n;
  logic                               reqValid_i;
  memBusPkg::reqOp_e                  reqOp_i;
  logic [cachePkg::addrWidth-1:0]     reqAddr_i;
  logic [memBusPkg::beatWidth-1:0]    wrData_i;
  logic [7:0]                         wrMask_i;
  logic                               rdReqReady_i;
  logic                               rdBeatValid_i;
  logic [memBusPkg::beatWidth-1:0]    rdBeatData_i;
  logic                               rdBeatLast_i;
  logic                               wrReqReady_i;
  logic                               reqReady_o;
  logic                               respValid_o;
  logic [memBusPkg::beatWidth-1:0]    respData_o;
  logic                               rdReqValid_o;
  logic [cachePkg::addrWidth-1:0]     rdAddr_o;
  logic                               wrReqValid_o;
  logic [cachePkg::addrWidth-1:0]     wrAddr_o;
  logic [cachePkg::lineWidth-1:0]     wrLine_o;

  integer        seed = 32'h4d8d_cd5d;
  int            failCount = 0;
  int            testsBad = 0;
  int            reqCnt = 0;
  int            respCnt = 0;
  int            testNum = 0;
  int            errAtStart = 0;
  logic [63:0]   memWord [int unsigned];
  logic [7:0]    sbByte [int unsigned];
  // bit 32 set marks a write-back, clear marks a line read
  logic [32:0]   busLog [$];
  logic [255:0]  lastWrLine;

  tbClkGen #(
    .periodNs   (periodNs),
    .resetCycles(3)
  ) tbClkGen_inst (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  dataCache #(
    .numSets(64)
  ) dataCache_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .reqOp_i      (reqOp_i),
    .reqAddr_i    (reqAddr_i),
    .wrData_i     (wrData_i),
    .wrMask_i     (wrMask_i),
    .rdReqReady_i (rdReqReady_i),
    .rdBeatValid_i(rdBeatValid_i),
    .rdBeatData_i (rdBeatData_i),
    .rdBeatLast_i (rdBeatLast_i),
    .wrReqReady_i (wrReqReady_i),
    .reqReady_o   (reqReady_o),
    .respValid_o  (respValid_o),
    .respData_o   (respData_o),
    .rdReqValid_o (rdReqValid_o),
    .rdAddr_o     (rdAddr_o),
    .wrReqValid_o (wrReqValid_o),
    .wrAddr_o     (wrAddr_o),
    .wrLine_o     (wrLine_o)
  );

  bind dataCache dataCache_props dataCache_props_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid_i),
    .reqReady_i  (reqReady_o),
    .respValid_i (respValid_o),
    .rdReqValid_i(rdReqValid_o),
    .rdReqReady_i(rdReqReady_i),
    .rdAddr_i    (rdAddr_o),
    .wrReqValid_i(wrReqValid_o),
    .wrReqReady_i(wrReqReady_i),
    .wrAddr_i    (wrAddr_o),
    .wrLine_i    (wrLine_o)
  );

  function automatic logic [31:0] makeAddr(input logic [20:0] tag, input logic [5:0] set,
                                           input logic [1:0] word);
    return {tag, set, word, 3'b000};
  endfunction

  // untouched memory holds its own address scrambled by a constant
  function automatic logic [63:0] defaultWord(input logic [31:0] addr);
    logic [31:0] pat;
    pat = addr ^ 32'h4d8d_cd5d;
    return {pat, pat};
  endfunction

  function automatic logic [63:0] readWord(input logic [31:0] addr);
    if (memWord.exists(addr)) begin
      return memWord[addr];
    end
    return defaultWord(addr);
  endfunction

  function automatic logic [7:0] expByte(input logic [31:0] addr);
    logic [63:0] w;
    if (sbByte.exists(addr)) begin
      return sbByte[addr];
    end
    w = defaultWord({addr[31:3], 3'b000});
    return w[8 * addr[2:0] +: 8];
  endfunction

  function automatic logic [63:0] expWord(input logic [31:0] addr);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) begin
      w[8 * b +: 8] = expByte({addr[31:3], 3'b000} + b);
    end
    return w;
  endfunction

  function automatic logic [255:0] expLine(input logic [31:0] base);
    logic [255:0] line;
    for (int w = 0; w < 4; w++) begin
      line[64 * w +: 64] = expWord(base + 8 * w);
    end
    return line;
  endfunction

  // store bytes land shifted by the low address bits
  function automatic void applyStore(input logic [31:0] addr, input logic [63:0] data,
                                     input logic [7:0] mask);
    int lane;
    for (int b = 0; b < 8; b++) begin
      lane = addr[2:0] + b;
      if (mask[b] && lane < 8) begin
        sbByte[{addr[31:3], 3'b000} + lane] = data[8 * b +: 8];
      end
    end
  endfunction

  function automatic int propErrors();
    return dataCache_inst.dataCache_props_inst.errCnt;
  endfunction

  task automatic checkValue(input string name, input logic [255:0] got,
                            input logic [255:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      failCount++;
    end
  endtask

  task automatic startTest();
    testNum++;
    errAtStart = failCount + propErrors();
  endtask

  task automatic reportTest(input string name);
    int errs;
    errs = failCount + propErrors() - errAtStart;
    if (errs == 0) begin
      $display("test %0d %s: ok", testNum, name);
    end else begin
      $display("test %0d %s: %0d errors", testNum, name, errs);
      testsBad++;
    end
  endtask

  // starts at posedge + 2, returns at posedge + 2 after the response
  task automatic issueReq(input memBusPkg::reqOp_e op, input logic [31:0] addr,
                          input logic [63:0] data, input logic [7:0] mask,
                          output logic [63:0] rdata, output int lat);
    reqValid_i = 1'b1;
    reqOp_i    = op;
    reqAddr_i  = addr;
    wrData_i   = data;
    wrMask_i   = mask;
    @(negedge clk);
    while (!reqReady_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    reqValid_i = 1'b0;
    reqCnt++;
    lat = 1;
    @(negedge clk);
    while (!respValid_o && lat < respLimit) begin
      @(negedge clk);
      lat++;
    end
    rdata = respData_o;
    if (!respValid_o) begin
      $display("[ERROR] %0t ns no response to the request for address %h", $time, addr);
      failCount++;
    end
    if (op == memBusPkg::opStore) begin
      checkValue("respData_o", rdata, '0);
      applyStore(addr, data, mask);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic serveWrite();
    int          delay;
    logic [31:0] addr;
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) @(negedge clk);
    @(posedge clk);
    #2;
    wrReqReady_i = 1'b1;
    @(negedge clk);
    addr       = wrAddr_o;
    lastWrLine = wrLine_o;
    busLog.push_back({1'b1, addr});
    for (int i = 0; i < memBusPkg::beatsPerLine; i++) begin
      memWord[addr + 8 * i] = wrLine_o[64 * i +: 64];
    end
    @(posedge clk);
    #2;
    wrReqReady_i = 1'b0;
  endtask

  task automatic serveRead();
    int          delay;
    logic [31:0] addr;
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) @(negedge clk);
    @(posedge clk);
    #2;
    rdReqReady_i = 1'b1;
    @(negedge clk);
    addr = rdAddr_o;
    busLog.push_back({1'b0, addr});
    @(posedge clk);
    #2;
    rdReqReady_i = 1'b0;
    for (int i = 0; i < memBusPkg::beatsPerLine; i++) begin
      rdBeatValid_i = 1'b1;
      rdBeatData_i  = readWord(addr + 8 * i);
      rdBeatLast_i  = (i == memBusPkg::beatsPerLine - 1);
      @(posedge clk);
      #2;
    end
    rdBeatValid_i = 1'b0;
    rdBeatLast_i  = 1'b0;
  endtask

  // memory side serves one transfer at a time
  initial begin : memoryModel
    rdReqReady_i  = 1'b0;
    rdBeatValid_i = 1'b0;
    rdBeatData_i  = '0;
    rdBeatLast_i  = 1'b0;
    wrReqReady_i  = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && wrReqValid_o) begin
        serveWrite();
      end else if (rst_n && rdReqValid_o) begin
        serveRead();
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && respValid_o) begin
      respCnt++;
    end
  end

  initial begin : watchdog
    #(timeoutCycles * periodNs);
    $display("[ERROR] watchdog expired after %0d cycles, simulation stopped", timeoutCycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [63:0]       rdata;
    int                lat;
    logic [31:0]       addrA;
    logic [31:0]       addrB;
    logic [31:0]       lineA;
    logic [31:0]       lineB;
    logic [31:0]       lineC;
    logic [31:0]       r;
    logic [31:0]       addr;
    memBusPkg::reqOp_e op;

    reqValid_i = 1'b0;
    reqOp_i    = memBusPkg::opLoad;
    reqAddr_i  = '0;
    wrData_i   = '0;
    wrMask_i   = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);

    startTest();
    checkValue("reqReady_o", reqReady_o, 1'b1);
    checkValue("respValid_o", respValid_o, 1'b0);
    checkValue("rdReqValid_o", rdReqValid_o, 1'b0);
    checkValue("wrReqValid_o", wrReqValid_o, 1'b0);
    reportTest("reset state");
    @(posedge clk);
    #2;

    startTest();
    addrA = makeAddr(21'h123, 6'd1, 2'd1);
    busLog.delete();
    issueReq(memBusPkg::opLoad, addrA, '0, '0, rdata, lat);
    checkValue("bus requests", busLog.size(), 1);
    checkValue("rdAddr_o", busLog[0], {1'b0, addrA[31:5], 5'b00000});
    checkValue("respData_o", rdata, expWord(addrA));
    issueReq(memBusPkg::opLoad, addrA, '0, '0, rdata, lat);
    checkValue("hit latency", lat, 1);
    checkValue("respData_o", rdata, expWord(addrA));
    checkValue("bus requests", busLog.size(), 1);
    reportTest("read miss then hit");

    startTest();
    addrB = makeAddr(21'h0a5, 6'd2, 2'd2);
    issueReq(memBusPkg::opLoad, addrB, '0, '0, rdata, lat);
    issueReq(memBusPkg::opStore, addrB, 64'h1122_3344_5566_7788, 8'b1010_0101, rdata, lat);
    checkValue("store hit latency", lat, 1);
    // unaligned store moves two bytes up by two lanes
    issueReq(memBusPkg::opStore, addrB + 2, 64'h0000_0000_0000_9abc, 8'h03, rdata, lat);
    issueReq(memBusPkg::opLoad, addrB, '0, '0, rdata, lat);
    checkValue("respData_o", rdata, expWord(addrB));
    reportTest("byte-masked store");

    startTest();
    lineA = makeAddr(21'h011, 6'd5, 2'd0);
    lineB = makeAddr(21'h022, 6'd5, 2'd0);
    lineC = makeAddr(21'h033, 6'd5, 2'd0);
    issueReq(memBusPkg::opStore, lineA + 8, 64'hdead_beef_0bad_f00d, 8'hf0, rdata, lat);
    busLog.delete();
    issueReq(memBusPkg::opLoad, lineB, '0, '0, rdata, lat);
    issueReq(memBusPkg::opLoad, lineC + 16, '0, '0, rdata, lat);
    checkValue("respData_o", rdata, expWord(lineC + 16));
    checkValue("bus requests", busLog.size(), 3);
    checkValue("first read address", busLog[0], {1'b0, lineB});
    checkValue("write-back address", busLog[1], {1'b1, lineA});
    checkValue("refill address", busLog[2], {1'b0, lineC});
    checkValue("wrLine_o", lastWrLine, expLine(lineA));
    // victim is now the clean way holding lineB
    busLog.delete();
    issueReq(memBusPkg::opLoad, lineA + 8, '0, '0, rdata, lat);
    checkValue("respData_o", rdata, expWord(lineA + 8));
    checkValue("bus requests", busLog.size(), 1);
    issueReq(memBusPkg::opLoad, lineC, '0, '0, rdata, lat);
    checkValue("hit latency", lat, 1);
    reportTest("dirty eviction");

    startTest();
    for (int i = 0; i < 24; i++) begin
      r    = $random(seed);
      addr = makeAddr(21'h100 + r[1:0], 6'd8 + r[3:2], r[5:4]);
      op   = r[6] ? memBusPkg::opStore : memBusPkg::opLoad;
      issueReq(op, addr, {$random(seed), $random(seed)}, r[15:8], rdata, lat);
      if (op == memBusPkg::opLoad) begin
        checkValue("respData_o", rdata, expWord(addr));
      end
    end
    reportTest("random traffic under back-pressure");

    startTest();
    reqValid_i = 1'b1;
    reqOp_i    = memBusPkg::opLoad;
    reqAddr_i  = addrA;
    @(negedge clk);
    while (!reqReady_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    reqAddr_i = addrA + 8;
    @(negedge clk);
    checkValue("respValid_o", respValid_o, 1'b1);
    checkValue("respData_o", respData_o, expWord(addrA));
    checkValue("reqReady_o", reqReady_o, 1'b1);
    @(posedge clk);
    #2;
    reqValid_i = 1'b0;
    reqCnt += 2;
    @(negedge clk);
    checkValue("respValid_o", respValid_o, 1'b1);
    checkValue("respData_o", respData_o, expWord(addrA + 8));
    @(posedge clk);
    #2;
    // the next request stays presented through a whole miss
    addr       = makeAddr(21'h044, 6'd20, 2'd3);
    reqValid_i = 1'b1;
    reqOp_i    = memBusPkg::opLoad;
    reqAddr_i  = addr;
    @(negedge clk);
    while (!reqReady_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    reqAddr_i = addrA;
    lat       = 1;
    @(negedge clk);
    while (!respValid_o && lat < respLimit) begin
      @(negedge clk);
      lat++;
    end
    checkValue("respValid_o", respValid_o, 1'b1);
    checkValue("respData_o", respData_o, expWord(addr));
    checkValue("reqReady_o", reqReady_o, 1'b1);
    @(posedge clk);
    #2;
    reqValid_i = 1'b0;
    reqCnt += 2;
    @(negedge clk);
    checkValue("respValid_o", respValid_o, 1'b1);
    checkValue("respData_o", respData_o, expWord(addrA));
    @(posedge clk);
    #2;
    checkValue("response count", respCnt, reqCnt);
    reportTest("back-to-back and queued requests");

    $display("tests run %0d, tests with errors %0d, check errors %0d, assertion errors %0d",
             testNum, testsBad, failCount, propErrors());
    if (failCount + propErrors() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/dataCache_props.sv ====
`timescale 1ns/1ns

module dataCache_props (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              reqValid_i,
  input  logic                              reqReady_i,
  input  logic                              respValid_i,
  input  logic                              rdReqValid_i,
  input  logic                              rdReqReady_i,
  input  logic [cachePkg::addrWidth-1:0]    rdAddr_i,
  input  logic                              wrReqValid_i,
  input  logic                              wrReqReady_i,
  input  logic [cachePkg::addrWidth-1:0]    wrAddr_i,
  input  logic [cachePkg::lineWidth-1:0]    wrLine_i
);

  int         errCnt = 0;
  logic [1:0] pending;

  // requests accepted but not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pending + (reqValid_i && reqReady_i) - respValid_i;
    end
  end

  resetQuiet: assert property (@(posedge clk)
    $rose(rst_n) |-> reqReady_i && !respValid_i && !rdReqValid_i && !wrReqValid_i)
  else begin
    errCnt = errCnt + 1;
    $error("outputs not in their idle values right after reset");
  end

  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
    rdReqValid_i && !rdReqReady_i |=> rdReqValid_i && $stable(rdAddr_i))
  else begin
    errCnt = errCnt + 1;
    $error("read request dropped or changed while stalled");
  end

  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    wrReqValid_i && !wrReqReady_i |=> wrReqValid_i && $stable(wrAddr_i) && $stable(wrLine_i))
  else begin
    errCnt = errCnt + 1;
    $error("write request dropped or changed while stalled");
  end

  busyNotReady: assert property (@(posedge clk) disable iff (!rst_n)
    (rdReqValid_i || wrReqValid_i) |-> !reqReady_i)
  else begin
    errCnt = errCnt + 1;
    $error("cache ready for a request during a memory transfer");
  end

  // each response belongs to exactly one accepted request
  respOwned: assert property (@(posedge clk) disable iff (!rst_n)
    respValid_i |-> pending == 2'd1)
  else begin
    errCnt = errCnt + 1;
    $error("response without exactly one outstanding request");
  end

  acceptFree: assert property (@(posedge clk) disable iff (!rst_n)
    (reqValid_i && reqReady_i) |-> (pending == 2'd0) || respValid_i)
  else begin
    errCnt = errCnt + 1;
    $error("request accepted while an earlier one is unanswered");
  end

endmodule

// ==== sim/tbClkGen.sv ====
`timescale 1ns/1ns

module tbClkGen #(
  parameter int periodNs    = 20,
  parameter int resetCycles = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(periodNs / 2) clk_o = ~clk_o;
    end
  end

  // release just after an edge so the first sampled cycle is clean
  initial begin
    rst_n_o = 1'b0;
    repeat (resetCycles) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

// ==== hw/dataCache.sv ====
`timescale 1ns/1ns

module dataCache #(
  parameter int numSets = 64
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 reqValid_i,
  input  memBusPkg::reqOp_e                    reqOp_i,
  input  logic [cachePkg::addrWidth-1:0]       reqAddr_i,
  input  logic [memBusPkg::beatWidth-1:0]      wrData_i,
  input  logic [7:0]                           wrMask_i,
  input  logic                                 rdReqReady_i,
  input  logic                                 rdBeatValid_i,
  input  logic [memBusPkg::beatWidth-1:0]      rdBeatData_i,
  input  logic                                 rdBeatLast_i,
  input  logic                                 wrReqReady_i,
  output logic                                 reqReady_o,
  output logic                                 respValid_o,
  output logic [memBusPkg::beatWidth-1:0]      respData_o,
  output logic                                 rdReqValid_o,
  output logic [cachePkg::addrWidth-1:0]       rdAddr_o,
  output logic                                 wrReqValid_o,
  output logic [cachePkg::addrWidth-1:0]       wrAddr_o,
  output logic [cachePkg::lineWidth-1:0]       wrLine_o
);

  localparam int indexWidth = $clog2(numSets);
  localparam int tagWidth   = cachePkg::addrWidth - cachePkg::offsetWidth - indexWidth;

  logic                                lookupEn;
  logic                                storeHit;
  logic                                refillWrite;
  logic [indexWidth-1:0]               reqIndex;
  logic [tagWidth-1:0]                 reqTag;
  logic [cachePkg::offsetWidth-1:0]    reqOffset;
  logic [memBusPkg::beatWidth-1:0]     storeData;
  logic [7:0]                          storeMask;
  logic                                hit;
  logic                                hitWay;
  logic                                victimWay;
  logic                                victimDirty;
  logic [tagWidth-1:0]                 victimTag;
  logic [cachePkg::lineWidth-1:0]      refillLine;

  cacheCtrl #(
    .numSets(numSets)
  ) cacheCtrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .reqOp_i      (reqOp_i),
    .reqAddr_i    (reqAddr_i),
    .wrData_i     (wrData_i),
    .wrMask_i     (wrMask_i),
    .rdReqReady_i (rdReqReady_i),
    .rdBeatLast_i (rdBeatLast_i),
    .wrReqReady_i (wrReqReady_i),
    .hit_i        (hit),
    .victimDirty_i(victimDirty),
    .victimTag_i  (victimTag),
    .reqReady_o   (reqReady_o),
    .respValid_o  (respValid_o),
    .rdReqValid_o (rdReqValid_o),
    .rdAddr_o     (rdAddr_o),
    .wrReqValid_o (wrReqValid_o),
    .wrAddr_o     (wrAddr_o),
    .lookupEn_o   (lookupEn),
    .storeHit_o   (storeHit),
    .refillWrite_o(refillWrite),
    .reqIndex_o   (reqIndex),
    .reqTag_o     (reqTag),
    .reqOffset_o  (reqOffset),
    .storeData_o  (storeData),
    .storeMask_o  (storeMask)
  );

  tagStore #(
    .numSets(numSets)
  ) tagStore_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookupEn_i   (lookupEn),
    .index_i      (reqIndex),
    .tag_i        (reqTag),
    .storeHit_i   (storeHit),
    .refillWrite_i(refillWrite),
    .hit_o        (hit),
    .hitWay_o     (hitWay),
    .victimWay_o  (victimWay),
    .victimDirty_o(victimDirty),
    .victimTag_o  (victimTag)
  );

  dataStore #(
    .numSets(numSets)
  ) dataStore_inst (
    .clk          (clk),
    .index_i      (reqIndex),
    .offset_i     (reqOffset),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeHit_i   (storeHit),
    .storeData_i  (storeData),
    .storeMask_i  (storeMask),
    .refillWrite_i(refillWrite),
    .refillLine_i (refillLine),
    .loadData_o   (respData_o),
    .victimLine_o (wrLine_o)
  );

  refillBuffer refillBuffer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .beatValid_i (rdBeatValid_i),
    .beatData_i  (rdBeatData_i),
    .beatLast_i  (rdBeatLast_i),
    .refillLine_o(refillLine)
  );

endmodule

// ==== hw/cacheCtrl.sv ====
`timescale 1ns/1ns

module cacheCtrl #(
  parameter int numSets = 64
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        reqValid_i,
  input  memBusPkg::reqOp_e                           reqOp_i,
  input  logic [cachePkg::addrWidth-1:0]              reqAddr_i,
  input  logic [memBusPkg::beatWidth-1:0]             wrData_i,
  input  logic [7:0]                                  wrMask_i,
  input  logic                                        rdReqReady_i,
  input  logic                                        rdBeatLast_i,
  input  logic                                        wrReqReady_i,
  input  logic                                        hit_i,
  input  logic                                        victimDirty_i,
  input  logic [cachePkg::addrWidth-cachePkg::offsetWidth-$clog2(numSets)-1:0] victimTag_i,
  output logic                                        reqReady_o,
  output logic                                        respValid_o,
  output logic                                        rdReqValid_o,
  output logic [cachePkg::addrWidth-1:0]              rdAddr_o,
  output logic                                        wrReqValid_o,
  output logic [cachePkg::addrWidth-1:0]              wrAddr_o,
  output logic                                        lookupEn_o,
  output logic                                        storeHit_o,
  output logic                                        refillWrite_o,
  output logic [$clog2(numSets)-1:0]                  reqIndex_o,
  output logic [cachePkg::addrWidth-cachePkg::offsetWidth-$clog2(numSets)-1:0] reqTag_o,
  output logic [cachePkg::offsetWidth-1:0]            reqOffset_o,
  output logic [memBusPkg::beatWidth-1:0]             storeData_o,
  output logic [7:0]                                  storeMask_o
);

  localparam int indexWidth = $clog2(numSets);
  localparam int indexLsb   = cachePkg::offsetWidth;
  localparam int tagLsb     = cachePkg::offsetWidth + indexWidth;

  cachePkg::ctrlState_e             stateQ;
  cachePkg::ctrlState_e             stateD;
  memBusPkg::reqOp_e                reqOpQ;
  logic [cachePkg::addrWidth-1:0]   reqAddrQ;
  logic [memBusPkg::beatWidth-1:0]  wrDataQ;
  logic [7:0]                       wrMaskQ;
  logic                             inLookup;
  logic                             loadHit;
  logic                             accept;

  assign inLookup = (stateQ == cachePkg::lookup);
  assign loadHit  = inLookup && hit_i && (reqOpQ == memBusPkg::opLoad);

  // a load hit frees the slot in its own response cycle
  assign reqReady_o = (stateQ == cachePkg::idle) || loadHit;
  assign accept     = reqValid_i && reqReady_o;

  assign respValid_o   = inLookup && hit_i;
  assign storeHit_o    = inLookup && hit_i && (reqOpQ == memBusPkg::opStore);
  assign refillWrite_o = (stateQ == cachePkg::replace);
  assign lookupEn_o    = accept;
  assign rdReqValid_o  = (stateQ == cachePkg::missReq);
  assign wrReqValid_o  = (stateQ == cachePkg::writeBack);

  // the stores read with the incoming index in the accept cycle
  assign reqIndex_o  = accept ? reqAddr_i[tagLsb-1:indexLsb] : reqAddrQ[tagLsb-1:indexLsb];
  assign reqTag_o    = reqAddrQ[cachePkg::addrWidth-1:tagLsb];
  assign reqOffset_o = reqAddrQ[cachePkg::offsetWidth-1:0];
  assign storeData_o = wrDataQ;
  assign storeMask_o = wrMaskQ;

  // line-aligned miss and victim addresses
  assign rdAddr_o = {reqAddrQ[cachePkg::addrWidth-1:indexLsb], {cachePkg::offsetWidth{1'b0}}};
  assign wrAddr_o = {victimTag_i, reqAddrQ[tagLsb-1:indexLsb], {cachePkg::offsetWidth{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= cachePkg::idle;
    end else begin
      stateQ <= stateD;
    end
  end

  // request latch
  always_ff @(posedge clk) begin
    if (accept) begin
      reqOpQ   <= reqOp_i;
      reqAddrQ <= reqAddr_i;
      wrDataQ  <= wrData_i;
      wrMaskQ  <= wrMask_i;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      cachePkg::idle: begin
        if (reqValid_i) begin
          stateD = cachePkg::lookup;
        end
      end
      cachePkg::lookup: begin
        if (hit_i) begin
          // back-to-back loads stay in lookup
          stateD = (loadHit && reqValid_i) ? cachePkg::lookup : cachePkg::idle;
        end else if (victimDirty_i) begin
          stateD = cachePkg::writeBack;
        end else begin
          stateD = cachePkg::missReq;
        end
      end
      cachePkg::writeBack: begin
        if (wrReqReady_i) begin
          stateD = cachePkg::missReq;
        end
      end
      cachePkg::missReq: begin
        if (rdReqReady_i) begin
          stateD = cachePkg::refill;
        end
      end
      cachePkg::refill: begin
        if (rdBeatLast_i) begin
          stateD = cachePkg::replace;
        end
      end
      cachePkg::replace: begin
        // re-run the lookup on the freshly written line
        stateD = cachePkg::lookup;
      end
      default: begin
        stateD = cachePkg::idle;
      end
    endcase
  end

endmodule

// ==== hw/dataStore.sv ====
`timescale 1ns/1ns

module dataStore #(
  parameter int numSets = 64
) (
  input  logic                                 clk,
  input  logic [$clog2(numSets)-1:0]           index_i,
  input  logic [cachePkg::offsetWidth-1:0]     offset_i,
  input  logic                                 hitWay_i,
  input  logic                                 victimWay_i,
  input  logic                                 storeHit_i,
  input  logic [memBusPkg::beatWidth-1:0]      storeData_i,
  input  logic [7:0]                           storeMask_i,
  input  logic                                 refillWrite_i,
  input  logic [cachePkg::lineWidth-1:0]       refillLine_i,
  output logic [memBusPkg::beatWidth-1:0]      loadData_o,
  output logic [cachePkg::lineWidth-1:0]       victimLine_o
);

  localparam int indexWidth = $clog2(numSets);
  localparam int laneBits   = $clog2(memBusPkg::beatWidth / 8);
  localparam int wordBits   = cachePkg::offsetWidth - laneBits;

  logic [cachePkg::lineWidth-1:0]    lineMem [cachePkg::numWays][numSets];
  logic [cachePkg::lineWidth-1:0]    wayLine [cachePkg::numWays];
  logic [cachePkg::lineWidth-1:0]    hitLine;
  logic [indexWidth-1:0]             idxQ;
  logic [wordBits-1:0]               wordSel;
  logic [memBusPkg::beatWidth-1:0]   laneData;
  logic [7:0]                        laneMask;

  assign wordSel = offset_i[cachePkg::offsetWidth-1:laneBits];

  // align store bytes to their lanes inside the word
  assign laneData = storeData_i << {offset_i[laneBits-1:0], 3'b000};
  assign laneMask = storeMask_i << offset_i[laneBits-1:0];

  // read address register, a write at the same edge is seen next cycle
  always_ff @(posedge clk) begin
    idxQ <= index_i;
  end

  always_comb begin
    for (int w = 0; w < cachePkg::numWays; w++) begin
      wayLine[w] = lineMem[w][idxQ];
    end
  end

  assign hitLine      = wayLine[hitWay_i];
  assign victimLine_o = wayLine[victimWay_i];

  // stores answer with zero data
  assign loadData_o = storeHit_i ? '0
                                 : hitLine[wordSel * memBusPkg::beatWidth +: memBusPkg::beatWidth];

  always_ff @(posedge clk) begin
    if (refillWrite_i) begin
      lineMem[victimWay_i][index_i] <= refillLine_i;
    end else if (storeHit_i) begin
      // byte-enable merge, unmasked bytes keep old data
      for (int b = 0; b < 8; b++) begin
        if (laneMask[b]) begin
          lineMem[hitWay_i][index_i][wordSel * memBusPkg::beatWidth + b * 8 +: 8] <=
            laneData[b * 8 +: 8];
        end
      end
    end
  end

endmodule

// ==== hw/tagStore.sv ====
`timescale 1ns/1ns

module tagStore #(
  parameter int numSets = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          lookupEn_i,
  input  logic [$clog2(numSets)-1:0]    index_i,
  input  logic [cachePkg::addrWidth-cachePkg::offsetWidth-$clog2(numSets)-1:0] tag_i,
  input  logic                          storeHit_i,
  input  logic                          refillWrite_i,
  output logic                          hit_o,
  output logic                          hitWay_o,
  output logic                          victimWay_o,
  output logic                          victimDirty_o,
  output logic [cachePkg::addrWidth-cachePkg::offsetWidth-$clog2(numSets)-1:0] victimTag_o
);

  localparam int indexWidth = $clog2(numSets);
  localparam int tagWidth   = cachePkg::addrWidth - cachePkg::offsetWidth - indexWidth;

  logic [tagWidth-1:0]                           tagMem [cachePkg::numWays][numSets];
  logic [cachePkg::numWays-1:0][numSets-1:0]     validQ;
  logic [cachePkg::numWays-1:0][numSets-1:0]     dirtyQ;
  logic [numSets-1:0]                            rrQ;
  logic [indexWidth-1:0]                         idxQ;
  logic [cachePkg::numWays-1:0]                  wayHit;

  // registered index, outputs follow one cycle after the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idxQ <= '0;
    end else if (lookupEn_i) begin
      idxQ <= index_i;
    end
  end

  always_comb begin
    for (int w = 0; w < cachePkg::numWays; w++) begin
      wayHit[w] = validQ[w][idxQ] && (tagMem[w][idxQ] == tag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // invalid way first, else the round-robin pointer
  always_comb begin
    if (!validQ[0][idxQ]) begin
      victimWay_o = 1'b0;
    end else if (!validQ[1][idxQ]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = rrQ[idxQ];
    end
  end

  assign victimDirty_o = validQ[victimWay_o][idxQ] && dirtyQ[victimWay_o][idxQ];
  assign victimTag_o   = tagMem[victimWay_o][idxQ];

  always_ff @(posedge clk) begin
    if (refillWrite_i) begin
      tagMem[victimWay_o][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      rrQ    <= '0;
    end else if (refillWrite_i) begin
      validQ[victimWay_o][index_i] <= 1'b1;
      dirtyQ[victimWay_o][index_i] <= 1'b0;
      // Pointer moves away from the way just filled.
      rrQ[index_i] <= ~rrQ[index_i];
    end else if (storeHit_i) begin
      dirtyQ[hitWay_o][index_i] <= 1'b1;
    end
  end

endmodule

// ==== hw/refillBuffer.sv ====
`timescale 1ns/1ns

module refillBuffer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              beatValid_i,
  input  logic [memBusPkg::beatWidth-1:0]   beatData_i,
  input  logic                              beatLast_i,
  output logic [cachePkg::lineWidth-1:0]    refillLine_o
);

  localparam int cntWidth = $clog2(memBusPkg::beatsPerLine);

  logic [cntWidth-1:0]              beatCnt;
  logic [cachePkg::lineWidth-1:0]   lineQ;

  // beat slot counter, wraps after the last beat of a burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      if (beatLast_i) begin
        beatCnt <= '0;
      end else begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // beats arrive in address order
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineQ[beatCnt * memBusPkg::beatWidth +: memBusPkg::beatWidth] <= beatData_i;
    end
  end

  assign refillLine_o = lineQ;

endmodule

// ==== hw/memBusPkg.sv ====
package memBusPkg;

  // width of one memory beat, same as the pipeline word
  localparam int beatWidth = 64;

  // beats in one line burst
  localparam int beatsPerLine = 4;

  // request opcode from the load/store stage
  typedef enum logic {
    opLoad  = 1'b0,
    opStore = 1'b1
  } reqOp_e;

endpackage

// ==== hw/cachePkg.sv ====
package cachePkg;

  // byte address seen by the pipeline
  localparam int addrWidth = 32;

  // byte offset inside one line
  localparam int offsetWidth = 5;

  // one line is 32 bytes
  localparam int lineWidth = 256;

  // set associativity
  localparam int numWays = 2;

  // controller states
  // writeBack is only entered when the chosen victim is dirty
  typedef enum logic [2:0] {
    idle      = 3'd0,
    lookup    = 3'd1,
    writeBack = 3'd2,
    missReq   = 3'd3,
    refill    = 3'd4,
    replace   = 3'd5
  } ctrlState_e;

endpackage
